// ==== Bender.yml ====
package:
  name: cpu

sources:
  - cpu_pkg.sv
  - reg_write_if.sv
  - fetch_stage.sv
  - register_file.sv
  - decode_stage.sv
  - execute_stage.sv
  - memory_stage.sv
  - cpu_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_cpu.sv

// ==== build.f ====
+incdir+.
cpu_pkg.sv
reg_write_if.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_cpu.sv

// ==== cpu_pkg.sv ====
package cpu_pkg;

  localparam int data_width      = 32;
  localparam int imm_width       = 16;
  localparam int num_regs        = 16;
  localparam int reg_addr_width  = 4;
  localparam int imem_depth      = 256;
  localparam int dmem_depth      = 256;
  localparam int pc_width        = $clog2(imem_depth);
  localparam int dmem_addr_width = $clog2(dmem_depth);

  // instruction fields
  localparam int op_msb  = 31;
  localparam int op_lsb  = 28;
  localparam int rs_msb  = 27;
  localparam int rs_lsb  = 24;
  localparam int rt_msb  = 23;
  localparam int rt_lsb  = 20;
  localparam int rd_msb  = 19;
  localparam int rd_lsb  = 16;
  localparam int imm_msb = 15;
  localparam int imm_lsb = 0;

  typedef logic [data_width-1:0]     data_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;
  typedef logic [pc_width-1:0]       pc_t;
  typedef logic [op_msb:0]           instr_t;

  typedef enum logic [3:0] {
    op_nop  = 4'd0,
    op_add  = 4'd1,
    op_sub  = 4'd2,
    op_and  = 4'd3,
    op_or   = 4'd4,
    op_xor  = 4'd5,
    op_slt  = 4'd6,
    op_addi = 4'd7,
    op_lw   = 4'd8,
    op_sw   = 4'd9,
    op_beq  = 4'd10,
    op_jmp  = 4'd11,
    op_halt = 4'd12
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt
  } alu_op_e;

  typedef struct packed {
    logic      valid;
    pc_t       pc;
    opcode_e   opcode;
    alu_op_e   alu_op;
    reg_addr_t rs;
    reg_addr_t rt;
    data_t     rs_data;
    data_t     rt_data;
    data_t     imm;
    reg_addr_t rd;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      uses_imm;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    opcode_e   opcode;
    data_t     alu_result;
    data_t     store_data;
    reg_addr_t rd;
    logic      reg_write;
    logic      mem_read;
  } ex_mem_t;

endpackage

// ==== cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      imem_we,
  input  pc_t       imem_addr,
  input  instr_t    imem_data,
  output logic      retire_valid,
  output reg_addr_t retire_rd,
  output data_t     retire_data,
  output logic      halted
);

  instr_t  if_instr;
  pc_t     if_pc;
  logic    if_valid;
  logic    stall;
  logic    redirect;
  pc_t     redirect_pc;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;

  reg_write_if ex_fwd ();
  reg_write_if wb ();

  fetch_stage i_fetch_stage (
    .clk         (clk),
    .rst         (rst),
    .imem_we     (imem_we),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .if_instr    (if_instr),
    .if_pc       (if_pc),
    .if_valid    (if_valid)
  );

  decode_stage i_decode_stage (
    .clk      (clk),
    .rst      (rst),
    .if_instr (if_instr),
    .if_pc    (if_pc),
    .if_valid (if_valid),
    .redirect (redirect),
    .wb       (wb.consumer),
    .stall    (stall),
    .id_ex    (id_ex)
  );

  execute_stage i_execute_stage (
    .clk         (clk),
    .rst         (rst),
    .id_ex       (id_ex),
    .ex_fwd      (ex_fwd.consumer),
    .wb          (wb.consumer),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ex_mem      (ex_mem)
  );

  memory_stage i_memory_stage (
    .clk    (clk),
    .rst    (rst),
    .ex_mem (ex_mem),
    .ex_fwd (ex_fwd.producer),
    .wb     (wb.producer),
    .halted (halted)
  );

  // committed register writes, r0 excluded
  assign retire_valid = wb.valid && wb.reg_write && (wb.rd != '0);
  assign retire_rd    = wb.rd;
  assign retire_data  = wb.data;

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  instr_t        if_instr,
  input  pc_t           if_pc,
  input  logic          if_valid,
  input  logic          redirect,
  reg_write_if.consumer wb,
  output logic          stall,
  output id_ex_t        id_ex
);

  opcode_e   opcode;
  alu_op_e   alu_op;
  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  data_t     rs_data;
  data_t     rt_data;
  data_t     imm_ext;
  logic      reg_write;
  logic      mem_read;
  logic      mem_write;
  logic      uses_imm;
  logic      rt_src;
  logic      dest_rd;
  id_ex_t    id_ex_d;

  assign rs      = if_instr[rs_msb:rs_lsb];
  assign rt      = if_instr[rt_msb:rt_lsb];
  assign rd      = if_instr[rd_msb:rd_lsb];
  assign imm_ext = {{(data_width-imm_width){if_instr[imm_msb]}}, if_instr[imm_msb:imm_lsb]};

  // unknown codes become nop
  always_comb begin
    case (if_instr[op_msb:op_lsb])
      op_add, op_sub, op_and, op_or, op_xor, op_slt,
      op_addi, op_lw, op_sw, op_beq, op_jmp, op_halt:
        opcode = opcode_e'(if_instr[op_msb:op_lsb]);
      default:
        opcode = op_nop;
    endcase
  end

  always_comb begin
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    uses_imm  = 1'b0;
    rt_src    = 1'b0;
    dest_rd   = 1'b0;
    case (opcode)
      op_add, op_sub, op_and, op_or, op_xor, op_slt: begin
        reg_write = 1'b1;
        rt_src    = 1'b1;
        dest_rd   = 1'b1;
      end
      op_addi: begin
        reg_write = 1'b1;
        uses_imm  = 1'b1;
      end
      op_lw: begin
        reg_write = 1'b1;
        mem_read  = 1'b1;
        uses_imm  = 1'b1;
      end
      op_sw: begin
        mem_write = 1'b1;
        uses_imm  = 1'b1;
        rt_src    = 1'b1;
      end
      op_beq: rt_src = 1'b1;
      default: ;
    endcase
    case (opcode)
      op_sub, op_beq: alu_op = alu_sub;
      op_and:         alu_op = alu_and;
      op_or:          alu_op = alu_or;
      op_xor:         alu_op = alu_xor;
      op_slt:         alu_op = alu_slt;
      default:        alu_op = alu_add;
    endcase
  end

  register_file i_register_file (
    .clk     (clk),
    .rst     (rst),
    .wb      (wb),
    .rs_addr (rs),
    .rt_addr (rt),
    .rs_data (rs_data),
    .rt_data (rt_data)
  );

  // load in EX feeding this instruction
  assign stall = if_valid && id_ex.valid && id_ex.mem_read && (id_ex.rd != '0) &&
                 ((id_ex.rd == rs) || (rt_src && (id_ex.rd == rt)));

  always_comb begin
    id_ex_d.valid     = if_valid && !stall && !redirect;
    id_ex_d.pc        = if_pc;
    id_ex_d.opcode    = opcode;
    id_ex_d.alu_op    = alu_op;
    id_ex_d.rs        = rs;
    id_ex_d.rt        = rt;
    id_ex_d.rs_data   = rs_data;
    id_ex_d.rt_data   = rt_data;
    id_ex_d.imm       = imm_ext;
    id_ex_d.rd        = dest_rd ? rd : rt;
    id_ex_d.reg_write = reg_write;
    id_ex_d.mem_read  = mem_read;
    id_ex_d.mem_write = mem_write;
    id_ex_d.uses_imm  = uses_imm;
  end

  ////////////////////////////////////////////////////////////
  // ID/EX
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    id_ex <= id_ex_d;
    if (rst) begin
      id_ex.valid <= 1'b0;
    end
  end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  id_ex_t        id_ex,
  reg_write_if.consumer ex_fwd,
  reg_write_if.consumer wb,
  output logic          redirect,
  output pc_t           redirect_pc,
  output ex_mem_t       ex_mem
);

  logic    ex_ok;
  logic    wb_ok;
  data_t   op_a;
  data_t   rt_val;
  data_t   op_b;
  data_t   alu_result;
  ex_mem_t ex_mem_d;

  assign ex_ok = ex_fwd.valid && ex_fwd.reg_write && (ex_fwd.rd != '0);
  assign wb_ok = wb.valid && wb.reg_write && (wb.rd != '0);

  // youngest producer first
  always_comb begin
    if (ex_ok && (ex_fwd.rd == id_ex.rs)) begin
      op_a = ex_fwd.data;
    end else if (wb_ok && (wb.rd == id_ex.rs)) begin
      op_a = wb.data;
    end else begin
      op_a = id_ex.rs_data;
    end
    if (ex_ok && (ex_fwd.rd == id_ex.rt)) begin
      rt_val = ex_fwd.data;
    end else if (wb_ok && (wb.rd == id_ex.rt)) begin
      rt_val = wb.data;
    end else begin
      rt_val = id_ex.rt_data;
    end
  end

  assign op_b = id_ex.uses_imm ? id_ex.imm : rt_val;

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex.alu_op)
      alu_add: alu_result = op_a + op_b;
      alu_sub: alu_result = op_a - op_b;
      alu_and: alu_result = op_a & op_b;
      alu_or:  alu_result = op_a | op_b;
      alu_xor: alu_result = op_a ^ op_b;
      alu_slt: alu_result = data_t'($signed(op_a) < $signed(op_b));
      default: alu_result = op_a + op_b;
    endcase
  end

  // predicted not-taken, so any transfer redirects
  assign redirect = id_ex.valid &&
                    (((id_ex.opcode == op_beq) && (op_a == rt_val)) ||
                     (id_ex.opcode == op_jmp));
  assign redirect_pc = (id_ex.opcode == op_jmp) ? id_ex.imm[pc_width-1:0] :
                       id_ex.pc + pc_t'(1) + id_ex.imm[pc_width-1:0];

  always_comb begin
    ex_mem_d.valid      = id_ex.valid;
    ex_mem_d.opcode     = id_ex.opcode;
    ex_mem_d.alu_result = alu_result;
    ex_mem_d.store_data = id_ex.mem_write ? rt_val : '0;
    ex_mem_d.rd         = id_ex.rd;
    ex_mem_d.reg_write  = id_ex.reg_write;
    ex_mem_d.mem_read   = id_ex.mem_read;
  end

  // EX/MEM
  always_ff @(posedge clk) begin
    ex_mem <= ex_mem_d;
    if (rst) begin
      ex_mem.valid <= 1'b0;
    end
  end

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   imem_we,
  input  pc_t    imem_addr,
  input  instr_t imem_data,
  input  logic   stall,
  input  logic   redirect,
  input  pc_t    redirect_pc,
  output instr_t if_instr,
  output pc_t    if_pc,
  output logic   if_valid
);

  instr_t imem [imem_depth];
  pc_t    pc;
  instr_t fetched;
  logic   fetched_halt;
  logic   halt_hold;

  // load port, contents survive reset
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_data;
    end
  end

  assign fetched      = imem[pc];
  assign fetched_halt = (fetched[op_msb:op_lsb] == op_halt);

  // halt issues once, then pc parks until a redirect
  always_ff @(posedge clk) begin
    if (rst) begin
      pc        <= '0;
      halt_hold <= 1'b0;
    end else if (redirect) begin
      pc        <= redirect_pc;
      halt_hold <= 1'b0;
    end else if (!stall && !halt_hold) begin
      if (fetched_halt) begin
        halt_hold <= 1'b1;
      end else begin
        pc <= pc + pc_t'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // IF/ID
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || redirect) begin
      if_valid <= 1'b0;
    end else if (!stall) begin
      if_valid <= !halt_hold;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      if_instr <= fetched;
      if_pc    <= pc;
    end
  end

endmodule

// ==== memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage import cpu_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  ex_mem_t       ex_mem,
  reg_write_if.producer ex_fwd,
  reg_write_if.producer wb,
  output logic          halted
);

  data_t                      dmem [dmem_depth];
  logic [dmem_addr_width-1:0] addr;
  data_t                      load_data;

  // word address from the low alu bits
  assign addr      = ex_mem.alu_result[dmem_addr_width-1:0];
  assign load_data = dmem[addr];

  always_ff @(posedge clk) begin
    if (ex_mem.valid && (ex_mem.opcode == op_sw)) begin
      dmem[addr] <= ex_mem.store_data;
    end
  end

  // loads show their address here, the stall keeps it unused
  assign ex_fwd.valid     = ex_mem.valid;
  assign ex_fwd.rd        = ex_mem.rd;
  assign ex_fwd.data      = ex_mem.alu_result;
  assign ex_fwd.reg_write = ex_mem.reg_write;

  ////////////////////////////////////////////////////////////
  // MEM/WB
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    wb.rd        <= ex_mem.rd;
    wb.data      <= ex_mem.mem_read ? load_data : ex_mem.alu_result;
    wb.reg_write <= ex_mem.reg_write;
    wb.valid     <= rst ? 1'b0 : ex_mem.valid;
  end

  // sticky once a halt is in writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      halted <= 1'b0;
    end else if (ex_mem.valid && (ex_mem.opcode == op_halt)) begin
      halted <= 1'b1;
    end
  end

endmodule

// ==== reg_write_if.sv ====
`timescale 1ns/1ps

// one registered write result, no handshake
interface reg_write_if import cpu_pkg::*; ();

  logic      valid;
  reg_addr_t rd;
  data_t     data;
  logic      reg_write;

  modport producer (
    output valid, rd, data, reg_write
  );

  modport consumer (
    input valid, rd, data, reg_write
  );

endinterface

// ==== register_file.sv ====
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  reg_write_if.consumer        wb,
  input  reg_addr_t            rs_addr,
  input  reg_addr_t            rt_addr,
  output data_t                rs_data,
  output data_t                rt_data
);

  data_t regs [num_regs];
  logic  wr_en;

  assign wr_en = wb.valid && wb.reg_write && (wb.rd != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // r0 reads zero, same-cycle write wins
  assign rs_data = (rs_addr == '0) ? '0 :
                   (wr_en && (wb.rd == rs_addr)) ? wb.data : regs[rs_addr];
  assign rt_data = (rt_addr == '0) ? '0 :
                   (wr_en && (wb.rd == rt_addr)) ? wb.data : regs[rt_addr];

endmodule

// ==== tb_model.svh ====
`ifndef tb_model_svh
`define tb_model_svh

// program under test and the register writes it should retire
instr_t    prog [$];
reg_addr_t exp_rd [$];
data_t     exp_data [$];

function automatic void emit_r(opcode_e op, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
  prog.push_back({op, rs, rt, rd, 16'h0000});
endfunction

function automatic void emit_i(opcode_e op, reg_addr_t rt, reg_addr_t rs, logic [15:0] imm);
  prog.push_back({op, rs, rt, 4'h0, imm});
endfunction

////////////////////////////////////////////////////////////
// sequential reference, one instruction per step
////////////////////////////////////////////////////////////

function automatic void run_model();
  data_t                      regs [num_regs];
  data_t                      dmem [dmem_depth];
  pc_t                        pc;
  instr_t                     ins;
  logic [3:0]                 code;
  data_t                      a;
  data_t                      b;
  data_t                      imm;
  data_t                      res;
  logic [dmem_addr_width-1:0] addr;
  reg_addr_t                  dst;
  logic                       wr;
  logic                       running;
  int                         steps;
  exp_rd.delete();
  exp_data.delete();
  foreach (regs[i]) begin
    regs[i] = '0;
  end
  foreach (dmem[i]) begin
    dmem[i] = '0;
  end
  pc      = '0;
  running = 1'b1;
  steps   = 0;
  while (running && steps < 4096) begin
    ins  = (pc < prog.size()) ? prog[pc] : '0;
    code = ins[op_msb:op_lsb];
    a    = regs[ins[rs_msb:rs_lsb]];
    b    = regs[ins[rt_msb:rt_lsb]];
    imm  = {{(data_width-imm_width){ins[imm_msb]}}, ins[imm_msb:imm_lsb]};
    addr = dmem_addr_width'(a + imm);
    res  = '0;
    wr   = code inside {op_add, op_sub, op_and, op_or, op_xor, op_slt, op_addi, op_lw};
    dst  = (code inside {op_addi, op_lw}) ? ins[rt_msb:rt_lsb] : ins[rd_msb:rd_lsb];
    pc   = pc + pc_t'(1);
    case (code)
      op_add:  res = a + b;
      op_sub:  res = a - b;
      op_and:  res = a & b;
      op_or:   res = a | b;
      op_xor:  res = a ^ b;
      op_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      op_addi: res = a + imm;
      op_lw:   res = dmem[addr];
      op_sw:   dmem[addr] = b;
      op_beq: begin
        if (a == b) begin
          pc = pc + imm[pc_width-1:0];
        end
      end
      op_jmp:  pc = imm[pc_width-1:0];
      op_halt: running = 1'b0;
      default: ;
    endcase
    // r0 never changes and never retires
    if (wr && dst != '0) begin
      regs[dst] = res;
      exp_rd.push_back(dst);
      exp_data.push_back(res);
    end
    steps++;
  end
endfunction

`endif

// ==== tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

  logic      clk;
  logic      rst;
  logic      imem_we;
  pc_t       imem_addr;
  instr_t    imem_data;
  logic      retire_valid;
  reg_addr_t retire_rd;
  data_t     retire_data;
  logic      halted;
  string     test_name;

  `include "tb_model.svh"

  cpu_top i_cpu_top (
    .clk          (clk),
    .rst          (rst),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_data    (imem_data),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halted       (halted)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  task automatic stop_run();
    $display("Regression failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic compare_rd(string name, reg_addr_t expected, reg_addr_t actual);
    if (expected !== actual) begin
      $display("Fail %s: rd expected %0d, actual %0d", name, expected, actual);
      stop_run();
    end
  endtask

  task automatic compare_data(string name, data_t expected, data_t actual);
    if (expected !== actual) begin
      $display("Fail %s: data expected %08h, actual %08h", name, expected, actual);
      stop_run();
    end
  endtask

  task automatic compare_flag(string name, logic expected, logic actual);
    if (expected !== actual) begin
      $display("Fail %s: halted expected %b, actual %b", name, expected, actual);
      stop_run();
    end
  endtask

  // each retire must match the next model write
  always @(negedge clk) begin
    if (!rst && retire_valid === 1'b1) begin
      if (exp_rd.size() == 0) begin
        $display("%s: write to r%0d retired but none was expected", test_name, retire_rd);
        stop_run();
      end else begin
        compare_rd(test_name, exp_rd.pop_front(), retire_rd);
        compare_data(test_name, exp_data.pop_front(), retire_data);
      end
    end
  end

  function automatic reg_addr_t pick_reg(reg_addr_t a, reg_addr_t b);
    reg_addr_t r;
    r = reg_addr_t'(1 + $urandom % 15);
    while (r == a || r == b) begin
      r = reg_addr_t'(1 + $urandom % 15);
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // program load and run
  ////////////////////////////////////////////////////////////

  task automatic load_program();
    @(posedge clk);
    rst <= 1'b1;
    foreach (prog[i]) begin
      @(posedge clk);
      imem_we   <= 1'b1;
      imem_addr <= pc_t'(i);
      imem_data <= prog[i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic run_program(string name);
    int cycles;
    test_name = name;
    run_model();
    load_program();
    @(negedge clk);
    compare_flag({name, " after reset"}, 1'b0, halted);
    cycles = 0;
    while (halted !== 1'b1) begin
      if (cycles >= 2000) begin
        $display("%s: timed out waiting for halted", name);
        stop_run();
      end
      @(negedge clk);
      cycles++;
    end
    // window where nothing may retire
    repeat (6) @(negedge clk);
    compare_flag(name, 1'b1, halted);
    if (exp_rd.size() != 0) begin
      $display("%s: %0d expected register writes never retired", name, exp_rd.size());
      stop_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic test_arith();
    opcode_e   ops [7];
    reg_addr_t ra;
    reg_addr_t rb;
    ops = '{op_add, op_sub, op_and, op_or, op_xor, op_slt, op_slt};
    prog.delete();
    for (int round = 0; round < 3; round++) begin
      ra = pick_reg(4'd0, 4'd0);
      rb = pick_reg(ra, 4'd0);
      // opposite signs so a signed slt differs from an unsigned one
      emit_i(op_addi, ra, 4'd0, 16'($urandom) & 16'h7fff);
      emit_i(op_addi, rb, 4'd0, 16'($urandom) | 16'h8000);
      foreach (ops[i]) begin
        // last slt runs with swapped operands
        if (i == 6) begin
          emit_r(ops[i], pick_reg(ra, rb), rb, ra);
        end else begin
          emit_r(ops[i], pick_reg(ra, rb), ra, rb);
        end
      end
      emit_i(op_addi, pick_reg(ra, rb), ra, 16'($urandom));
    end
    emit_i(op_halt, 4'd0, 4'd0, 16'h0);
    run_program("arithmetic");
  endtask

  task automatic test_forwarding();
    prog.delete();
    emit_i(op_addi, 4'd1, 4'd0, 16'($urandom));
    emit_i(op_addi, 4'd2, 4'd1, 16'($urandom));
    emit_r(op_add, 4'd3, 4'd1, 4'd2);
    emit_r(op_xor, 4'd4, 4'd1, 4'd3);
    emit_r(op_or, 4'd5, 4'd2, 4'd4);
    emit_i(op_nop, 4'd0, 4'd0, 16'h0);
    emit_r(op_add, 4'd6, 4'd5, 4'd4);
    emit_i(op_nop, 4'd0, 4'd0, 16'h0);
    emit_i(op_nop, 4'd0, 4'd0, 16'h0);
    emit_r(op_sub, 4'd7, 4'd6, 4'd5);
    // newer of two in-flight writes to r8 must win
    emit_i(op_addi, 4'd8, 4'd7, 16'($urandom));
    emit_i(op_addi, 4'd8, 4'd6, 16'($urandom));
    emit_r(op_add, 4'd9, 4'd8, 4'd8);
    emit_i(op_halt, 4'd0, 4'd0, 16'h0);
    run_program("forwarding");
  endtask

  task automatic test_load_store();
    prog.delete();
    emit_i(op_addi, 4'd1, 4'd0, 16'(1 + $urandom % 200));
    emit_i(op_addi, 4'd2, 4'd0, 16'($urandom));
    emit_i(op_sw, 4'd2, 4'd1, 16'd3);
    emit_i(op_lw, 4'd3, 4'd1, 16'd3);
    emit_r(op_add, 4'd4, 4'd3, 4'd2);
    emit_i(op_lw, 4'd5, 4'd1, 16'd3);
    emit_r(op_sub, 4'd6, 4'd2, 4'd5);
    emit_i(op_sw, 4'd6, 4'd1, 16'hffff);
    emit_i(op_lw, 4'd7, 4'd1, 16'hffff);
    emit_i(op_nop, 4'd0, 4'd0, 16'h0);
    emit_r(op_xor, 4'd8, 4'd7, 4'd4);
    emit_i(op_halt, 4'd0, 4'd0, 16'h0);
    run_program("load_store");
  endtask

  task automatic test_branches();
    prog.delete();
    emit_i(op_addi, 4'd1, 4'd0, 16'd5);
    emit_i(op_addi, 4'd2, 4'd0, 16'd5);
    emit_i(op_beq, 4'd2, 4'd1, 16'd2);
    emit_i(op_addi, 4'd3, 4'd0, 16'd111);
    emit_i(op_addi, 4'd4, 4'd0, 16'd222);
    emit_i(op_beq, 4'd3, 4'd1, 16'd1);
    emit_i(op_addi, 4'd5, 4'd0, 16'd7);
    emit_i(op_jmp, 4'd0, 4'd0, 16'd10);
    emit_i(op_addi, 4'd6, 4'd0, 16'd333);
    emit_i(op_addi, 4'd7, 4'd0, 16'd444);
    emit_i(op_addi, 4'd8, 4'd5, 16'd1);
    // counting loop closed by the backward beq at 13
    emit_i(op_addi, 4'd9, 4'd9, 16'd1);
    emit_i(op_beq, 4'd1, 4'd9, 16'd1);
    emit_i(op_beq, 4'd0, 4'd0, 16'hfffd);
    emit_i(op_halt, 4'd0, 4'd0, 16'h0);
    emit_i(op_addi, 4'd10, 4'd0, 16'd99);
    run_program("branches");
  endtask

  task automatic test_zero_halt();
    prog.delete();
    emit_i(op_addi, 4'd0, 4'd0, 16'd55);
    emit_i(op_addi, 4'd1, 4'd0, 16'd9);
    emit_r(op_add, 4'd0, 4'd1, 4'd1);
    emit_r(op_add, 4'd2, 4'd0, 4'd1);
    emit_r(op_or, 4'd3, 4'd1, 4'd0);
    emit_i(op_halt, 4'd0, 4'd0, 16'h0);
    emit_i(op_addi, 4'd4, 4'd0, 16'd1);
    emit_i(op_addi, 4'd5, 4'd0, 16'd2);
    run_program("zero_halt");
  endtask

  initial begin
    rst       = 1'b1;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    test_name = "reset";
    void'($urandom(32'h5ee5c72d));
    test_arith();
    test_forwarding();
    test_load_store();
    test_branches();
    test_zero_halt();
    $display("Regression passed");
    $finish;
  end

endmodule
